// ==== Makefile ====
# Verilator build and run for rv_core
# override any variable on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= rv_core_tb
LINT_TOP  ?= rv_core_top
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only if the log holds the pass message
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/rv_core_consts.svh ====
// shared constants for the rv_core design
// opcodes cover only the supported RV32I subset
// reset PC is a byte address, and fetches are always word aligned
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// architectural registers, x0 included
`define RV_NUM_REGS 32

// major opcodes, bits [6:0] of the instruction
`define RV_OPC_OP     7'b0110011
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111
`define RV_OPC_SYSTEM 7'b1110011

`endif

// ==== rtl/rv_core_pkg.sv ====
// types shared by the rv_core blocks
// enum encodings are internal and never leave the core
package rv_core_pkg;

	// data word, also used for pc, instruction and immediate
	typedef logic [31:0] word_t;

	// register index x0..x31
	typedef logic [4:0] reg_idx_t;

	// alu operations
	// pass_b forwards operand b untouched, used by lui
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_PASS_B
	} alu_op_e;

	// operand a source
	typedef enum logic {
		SRC_A_RS1,
		SRC_A_PC
	} src_a_e;

	// operand b source
	typedef enum logic {
		SRC_B_RS2,
		SRC_B_IMM
	} src_b_e;

	// register writeback source
	typedef enum logic {
		WB_ALU,
		WB_LINK
	} wb_sel_e;

	// next pc choice
	typedef enum logic [1:0] {
		PC_SEQ,
		PC_JUMP,
		PC_REG_JUMP
	} pc_sel_e;

endpackage

// ==== rtl/rv_core_top.sv ====
// rv_core top, single-issue RV32I subset core
// instructions fetched over a read-only APB master, no data port
// trace ports show each register write with the pc that made it
module rv_core_top (
	input  logic                  clk,
	input  logic                  arst_n,
	output rv_core_pkg::word_t    paddr,
	output logic                  psel,
	output logic                  penable,
	input  rv_core_pkg::word_t    prdata,
	input  logic                  pready,
	input  logic                  pslverr,
	output logic                  wb_valid,
	output rv_core_pkg::reg_idx_t wb_rd,
	output rv_core_pkg::word_t    wb_data,
	output rv_core_pkg::word_t    wb_pc,
	output logic                  halted,
	output logic                  fault
);
	import rv_core_pkg::*;

	word_t    pc;
	word_t    inst;
	word_t    next_pc;
	word_t    rdata1;
	word_t    rdata2;
	word_t    wdata;
	reg_idx_t waddr;
	logic     exec_valid;
	logic     we;
	logic     stop;
	logic     stop_illegal;

	// decoded instruction bundle
	rv_dec_if dec_if ();

	rv_fetch_apb u_fetch (
		.clk          (clk),
		.arst_n       (arst_n),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.pc           (pc),
		.inst         (inst),
		.exec_valid   (exec_valid),
		.next_pc      (next_pc),
		.stop         (stop),
		.stop_illegal (stop_illegal),
		.halted       (halted),
		.fault        (fault)
	);

	rv_decoder u_decoder (
		.inst (inst),
		.dec  (dec_if.decoder)
	);

	rv_regfile u_regfile (
		.clk    (clk),
		.arst_n (arst_n),
		.dec    (dec_if.regfile),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.we     (we),
		.waddr  (waddr),
		.wdata  (wdata)
	);

	rv_execute u_execute (
		.pc           (pc),
		.exec_valid   (exec_valid),
		.dec          (dec_if.execute),
		.rdata1       (rdata1),
		.rdata2       (rdata2),
		.we           (we),
		.waddr        (waddr),
		.wdata        (wdata),
		.next_pc      (next_pc),
		.stop         (stop),
		.stop_illegal (stop_illegal),
		.wb_valid     (wb_valid),
		.wb_rd        (wb_rd),
		.wb_data      (wb_data),
		.wb_pc        (wb_pc)
	);

endmodule

// ==== rtl/rv_dec_if.sv ====
// decoded instruction bundle, decoder to regfile and execute
// purely combinational, no clock inside
interface rv_dec_if;
	import rv_core_pkg::*;

	// register fields
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	word_t    imm;

	// control fields
	alu_op_e  alu_op;
	src_a_e   src_a;
	src_b_e   src_b;
	wb_sel_e  wb_sel;
	pc_sel_e  pc_sel;
	logic     reg_write;
	logic     halt;
	logic     illegal;

	modport decoder (
		output rs1, rs2, rd, imm, alu_op, src_a, src_b, wb_sel, pc_sel,
		output reg_write, halt, illegal
	);

	// read ports only need the source indices
	modport regfile (input rs1, rs2);

	modport execute (
		input rd, imm, alu_op, src_a, src_b, wb_sel, pc_sel, reg_write, halt, illegal
	);

endinterface

// ==== rtl/rv_decoder.sv ====
// RV32I subset decoder, purely combinational
// shifts, loads, stores, branches and CSRs decode as illegal
// only the exact EBREAK word halts, any other SYSTEM encoding is illegal
`include "rv_core_consts.svh"

module rv_decoder (
	input rv_core_pkg::word_t inst,
	rv_dec_if.decoder         dec
);
	import rv_core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_u;
	word_t      imm_j;
	// alu op shared by OP and OP-IMM
	alu_op_e    f3_op;
	logic       f3_ok;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	// funct3 to alu op
	always_comb begin
		f3_ok = 1'b1;
		case (funct3)
			3'b000: f3_op = ALU_ADD;
			3'b010: f3_op = ALU_SLT;
			3'b011: f3_op = ALU_SLTU;
			3'b100: f3_op = ALU_XOR;
			3'b110: f3_op = ALU_OR;
			3'b111: f3_op = ALU_AND;
			// sll, srl, sra not supported
			default: begin
				f3_op = ALU_ADD;
				f3_ok = 1'b0;
			end
		endcase
	end

	assign dec.rs1 = inst[19:15];
	assign dec.rs2 = inst[24:20];
	assign dec.rd  = inst[11:7];

	always_comb begin
		// defaults describe a plain register-register add with no effect
		dec.imm       = imm_i;
		dec.alu_op    = ALU_ADD;
		dec.src_a     = SRC_A_RS1;
		dec.src_b     = SRC_B_RS2;
		dec.wb_sel    = WB_ALU;
		dec.pc_sel    = PC_SEQ;
		dec.reg_write = 1'b0;
		dec.halt      = 1'b0;
		dec.illegal   = 1'b0;
		case (opcode)
			`RV_OPC_OP: begin
				if (funct7 == 7'b0000000 && f3_ok) begin
					dec.alu_op    = f3_op;
					dec.reg_write = 1'b1;
				end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					dec.alu_op    = ALU_SUB;
					dec.reg_write = 1'b1;
				end else begin
					dec.illegal = 1'b1;
				end
			end
			`RV_OPC_OP_IMM: begin
				dec.src_b     = SRC_B_IMM;
				dec.alu_op    = f3_op;
				dec.reg_write = f3_ok;
				dec.illegal   = !f3_ok;
			end
			`RV_OPC_LUI: begin
				dec.imm       = imm_u;
				dec.src_b     = SRC_B_IMM;
				dec.alu_op    = ALU_PASS_B;
				dec.reg_write = 1'b1;
			end
			`RV_OPC_AUIPC: begin
				dec.imm       = imm_u;
				dec.src_a     = SRC_A_PC;
				dec.src_b     = SRC_B_IMM;
				dec.reg_write = 1'b1;
			end
			`RV_OPC_JAL: begin
				// alu forms the target pc+imm, rd gets pc+4
				dec.imm       = imm_j;
				dec.src_a     = SRC_A_PC;
				dec.src_b     = SRC_B_IMM;
				dec.wb_sel    = WB_LINK;
				dec.pc_sel    = PC_JUMP;
				dec.reg_write = 1'b1;
			end
			`RV_OPC_JALR: begin
				if (funct3 == 3'b000) begin
					dec.src_b     = SRC_B_IMM;
					dec.wb_sel    = WB_LINK;
					dec.pc_sel    = PC_REG_JUMP;
					dec.reg_write = 1'b1;
				end else begin
					dec.illegal = 1'b1;
				end
			end
			`RV_OPC_SYSTEM: begin
				// ebreak is 0x00100073, nothing else in SYSTEM
				if (inst == 32'h0010_0073)
					dec.halt = 1'b1;
				else
					dec.illegal = 1'b1;
			end
			default: dec.illegal = 1'b1;
		endcase

		a_halt_xor_illegal: assert (!(dec.halt && dec.illegal))
			else $error("decoder raised halt and illegal together");
	end

endmodule

// ==== rtl/rv_execute.sv ====
// operand select, alu, writeback mux and next pc
// combinational, everything qualified by exec_valid
// the alu adder also forms jump targets, so jal uses pc+imm on a/b
module rv_execute (
	input  rv_core_pkg::word_t    pc,
	input  logic                  exec_valid,
	rv_dec_if.execute             dec,
	input  rv_core_pkg::word_t    rdata1,
	input  rv_core_pkg::word_t    rdata2,
	output logic                  we,
	output rv_core_pkg::reg_idx_t waddr,
	output rv_core_pkg::word_t    wdata,
	output rv_core_pkg::word_t    next_pc,
	output logic                  stop,
	output logic                  stop_illegal,
	output logic                  wb_valid,
	output rv_core_pkg::reg_idx_t wb_rd,
	output rv_core_pkg::word_t    wb_data,
	output rv_core_pkg::word_t    wb_pc
);
	import rv_core_pkg::*;

	word_t op_a;
	word_t op_b;
	word_t alu_res;
	word_t link;

	assign op_a = (dec.src_a == SRC_A_PC)  ? pc      : rdata1;
	assign op_b = (dec.src_b == SRC_B_IMM) ? dec.imm : rdata2;

	always_comb begin
		case (dec.alu_op)
			ALU_ADD:    alu_res = op_a + op_b;
			ALU_SUB:    alu_res = op_a - op_b;
			ALU_AND:    alu_res = op_a & op_b;
			ALU_OR:     alu_res = op_a | op_b;
			ALU_XOR:    alu_res = op_a ^ op_b;
			// compares give 0 or 1
			ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
			ALU_PASS_B: alu_res = op_b;
			default:    alu_res = '0;
		endcase
	end

	// return address for jal/jalr, also the sequential pc
	assign link = pc + 32'd4;

	assign wdata = (dec.wb_sel == WB_LINK) ? link : alu_res;

	always_comb begin
		case (dec.pc_sel)
			PC_JUMP:     next_pc = alu_res;
			// jalr clears bit 0 of rs1+imm
			PC_REG_JUMP: next_pc = {alu_res[31:1], 1'b0};
			default:     next_pc = link;
		endcase
	end

	// writes to x0 dropped here, so trace never shows them
	assign we    = exec_valid && dec.reg_write && (dec.rd != '0);
	assign waddr = dec.rd;

	assign stop         = exec_valid && (dec.halt || dec.illegal);
	assign stop_illegal = exec_valid && dec.illegal;

	// trace mirrors the register write
	assign wb_valid = we;
	assign wb_rd    = dec.rd;
	assign wb_data  = wdata;
	assign wb_pc    = pc;

	always_comb begin
		a_we_needs_exec: assert (!(we && !exec_valid))
			else $error("register write outside the execute cycle");
	end

endmodule

// ==== rtl/rv_fetch_apb.sv ====
// pc, read-only APB master and instruction register
// one instruction in flight: setup, access (stretched by pready), execute
// pslverr or a stop from execute parks the FSM in halt until reset
// paddr is the pc itself, so the program must be word aligned
`include "rv_core_consts.svh"

module rv_fetch_apb (
	input  logic               clk,
	input  logic               arst_n,
	output rv_core_pkg::word_t paddr,
	output logic               psel,
	output logic               penable,
	input  rv_core_pkg::word_t prdata,
	input  logic               pready,
	input  logic               pslverr,
	output rv_core_pkg::word_t pc,
	output rv_core_pkg::word_t inst,
	output logic               exec_valid,
	input  rv_core_pkg::word_t next_pc,
	input  logic               stop,
	input  logic               stop_illegal,
	output logic               halted,
	output logic               fault
);
	import rv_core_pkg::*;

	typedef enum logic [1:0] {
		ST_SETUP,
		ST_ACCESS,
		ST_EXEC,
		ST_HALT
	} state_e;

	state_e state;
	word_t  pc_q;
	// instruction register, payload only
	word_t  inst_q;
	logic   fault_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= ST_SETUP;
			pc_q    <= `RV_RESET_PC;
			fault_q <= 1'b0;
		end else begin
			case (state)
				ST_SETUP: state <= ST_ACCESS;
				ST_ACCESS: begin
					// wait here while the slave holds pready low
					if (pready) begin
						if (pslverr) begin
							state   <= ST_HALT;
							fault_q <= 1'b1;
						end else begin
							state <= ST_EXEC;
						end
					end
				end
				ST_EXEC: begin
					if (stop) begin
						state   <= ST_HALT;
						// ebreak halts cleanly, illegal halts with fault
						fault_q <= stop_illegal;
					end else begin
						state <= ST_SETUP;
						pc_q  <= next_pc;
					end
				end
				default: state <= ST_HALT;
			endcase
		end
	end

	// capture read data on the completing access cycle
	always_ff @(posedge clk) begin
		if (state == ST_ACCESS && pready && !pslverr)
			inst_q <= prdata;
	end

	assign paddr      = pc_q;
	assign psel       = (state == ST_SETUP) || (state == ST_ACCESS);
	assign penable    = (state == ST_ACCESS);
	assign pc         = pc_q;
	assign inst       = inst_q;
	assign exec_valid = (state == ST_EXEC);
	assign halted     = (state == ST_HALT);
	assign fault      = fault_q;

	// address held from setup until the transfer completes
	a_paddr_stable: assert property (@(posedge clk) disable iff (!arst_n)
		psel && !(penable && pready) |=> $stable(paddr))
		else $error("paddr changed during an open APB transfer");

	// no new transfer once halted
	a_no_psel_halted: assert property (@(posedge clk) disable iff (!arst_n)
		halted |=> !psel)
		else $error("psel raised after halt");

endmodule

// ==== rtl/rv_regfile.sv ====
// x1..x31 general registers, x0 is hardwired zero
// reads are combinational, so a write shows on the next cycle
module rv_regfile (
	input  logic                  clk,
	input  logic                  arst_n,
	rv_dec_if.regfile             dec,
	output rv_core_pkg::word_t    rdata1,
	output rv_core_pkg::word_t    rdata2,
	input  logic                  we,
	input  rv_core_pkg::reg_idx_t waddr,
	input  rv_core_pkg::word_t    wdata
);
	import rv_core_pkg::*;

	`include "rv_core_consts.svh"

	// no storage for x0
	word_t regs [1:`RV_NUM_REGS-1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < `RV_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 reads as zero
	assign rdata1 = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
	assign rdata2 = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

endmodule

// ==== rv_core.f ====
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/rv_dec_if.sv
rtl/rv_fetch_apb.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_core_top.sv
verif/rv_core_tb.sv

// ==== verif/rv_core_tb.sv ====
// directed testbench for rv_core_top
// instruction memory is 64 words from address 0 and fetches beyond it get pslverr
// a reference model steps the loaded program on every traced write or halt
// wait states come from $random with a fixed seed when use_waits is set
`include "rv_core_consts.svh"

module rv_core_tb;
	import rv_core_pkg::*;

	localparam int    MEM_WORDS     = 64;
	localparam word_t MEM_BYTES     = 32'd256;
	localparam word_t EBREAK        = 32'h0010_0073;
	localparam int    EVENT_TIMEOUT = 200;
	localparam int    HALT_WINDOW   = 20;
	localparam int    MAX_STEPS     = 256;

	logic     clk;
	logic     arst_n;
	word_t    paddr;
	logic     psel;
	logic     penable;
	word_t    prdata;
	logic     pready;
	logic     pslverr;
	logic     wb_valid;
	reg_idx_t wb_rd;
	word_t    wb_data;
	word_t    wb_pc;
	logic     halted;
	logic     fault;

	word_t  mem [0:MEM_WORDS-1];
	word_t  prog [$];
	// reference model state
	word_t  mregs [0:`RV_NUM_REGS-1];
	word_t  mpc;
	string  test_name;
	int     errors;
	int     stall_count;
	logic   use_waits;
	logic   check_spacing;
	integer seed = 32'h88afa6f6;
	word_t  rnd;
	word_t  setup_addr;
	logic   was_setup;

	rv_core_top dut (
		.clk      (clk),
		.arst_n   (arst_n),
		.paddr    (paddr),
		.psel     (psel),
		.penable  (penable),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data),
		.wb_pc    (wb_pc),
		.halted   (halted),
		.fault    (fault)
	);

	always #4 clk = ~clk;

	// APB responder answers each setup and each stalled access cycle
	always @(posedge clk) begin
		if (psel && !(penable && pready)) begin
			rnd = $random(seed);
			pready  <= use_waits ? rnd[0] : 1'b1;
			pslverr <= (paddr >= MEM_BYTES);
			prdata  <= (paddr >= MEM_BYTES) ? 32'd0 : mem[paddr[7:2]];
		end else begin
			pready  <= 1'b0;
			pslverr <= 1'b0;
		end
	end

	// paddr must hold from setup through every stalled access
	// the access phase follows the setup cycle at once
	always @(negedge clk) begin
		if (was_setup)
			check_flag("penable after setup", 1'b1, psel && penable);
		if (psel && !penable) begin
			setup_addr = paddr;
		end else if (psel && penable) begin
			check_word("paddr stable", setup_addr, paddr);
			if (!pready)
				stall_count++;
		end
		was_setup = arst_n && psel && !penable;
	end

	task automatic check_word(input string what, input word_t exp, input word_t act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_idx(input string what, input reg_idx_t exp, input reg_idx_t act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s %s: expected x%0d, actual x%0d", test_name, what, exp, act);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	// instruction encoders
	function automatic word_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
			input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `RV_OPC_OP};
	endfunction

	function automatic word_t enc_i(input int imm, input int rs1, input int f3, input int rd,
			input logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic word_t enc_u(input int imm, input int rd, input logic [6:0] opc);
		return {imm[19:0], rd[4:0], opc};
	endfunction

	function automatic word_t enc_j(input int off, input int rd);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `RV_OPC_JAL};
	endfunction

	function automatic logic f3_legal(input logic [2:0] f3);
		return f3 inside {3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
	endfunction

	// ALU rule for the funct3 values shared by OP and OP-IMM
	function automatic word_t alu_f3(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			3'b000: return a + b;
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b110: return a | b;
			3'b111: return a & b;
			default: return 32'd0;
		endcase
	endfunction

	// one instruction of the reference model
	task automatic model_step(output logic wr, output reg_idx_t rd, output word_t data,
			output logic stop, output logic flt);
		word_t      inst;
		word_t      rs1v;
		word_t      rs2v;
		word_t      imm_i;
		word_t      imm_u;
		word_t      npc;
		logic [2:0] f3;
		logic       ok;
		wr = 1'b0;
		stop = 1'b0;
		flt = 1'b0;
		data = '0;
		rd = '0;
		if (mpc >= MEM_BYTES) begin
			// bus error on the fetch
			stop = 1'b1;
			flt = 1'b1;
		end else begin
			inst = mem[mpc[7:2]];
			rd = inst[11:7];
			f3 = inst[14:12];
			rs1v = mregs[inst[19:15]];
			rs2v = mregs[inst[24:20]];
			imm_i = {{20{inst[31]}}, inst[31:20]};
			imm_u = {inst[31:12], 12'b0};
			npc = mpc + 32'd4;
			ok = 1'b1;
			wr = 1'b1;
			case (inst[6:0])
				`RV_OPC_OP: begin
					if (inst[31:25] == 7'h20 && f3 == 3'b000)
						data = rs1v - rs2v;
					else if (inst[31:25] == 7'h00 && f3_legal(f3))
						data = alu_f3(f3, rs1v, rs2v);
					else
						ok = 1'b0;
				end
				`RV_OPC_OP_IMM: begin
					ok = f3_legal(f3);
					data = alu_f3(f3, rs1v, imm_i);
				end
				`RV_OPC_LUI: data = imm_u;
				`RV_OPC_AUIPC: data = mpc + imm_u;
				`RV_OPC_JAL: begin
					data = mpc + 32'd4;
					npc = mpc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
				end
				`RV_OPC_JALR: begin
					ok = (f3 == 3'b000);
					data = mpc + 32'd4;
					npc = (rs1v + imm_i) & ~32'd1;
				end
				`RV_OPC_SYSTEM: begin
					// only the exact ebreak word stops cleanly
					wr = 1'b0;
					stop = 1'b1;
					flt = (inst != EBREAK);
				end
				default: ok = 1'b0;
			endcase
			if (!ok) begin
				wr = 1'b0;
				stop = 1'b1;
				flt = 1'b1;
			end
			wr = wr && (rd != 5'd0);
			if (wr)
				mregs[rd] = data;
			if (!stop)
				mpc = npc;
		end
	endtask

	// program from prog with the rest filled by addi x0 carrying the word index
	task automatic load_program();
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = (i < prog.size()) ? prog[i] : enc_i(i, 0, 0, 0, `RV_OPC_OP_IMM);
		prog.delete();
	endtask

	task automatic apply_reset();
		@(posedge clk);
		arst_n <= 1'b0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
	endtask

	// wait for the next traced write or halt and count the cycles in gap
	task automatic wait_event(output word_t gap, output logic got);
		gap = '0;
		got = 1'b0;
		for (int i = 0; i < EVENT_TIMEOUT && !got; i++) begin
			@(negedge clk);
			gap = gap + 32'd1;
			got = wb_valid || halted;
		end
		if (!got) begin
			errors++;
			$display("%s: no register write and no halt within %0d cycles", test_name,
				EVENT_TIMEOUT);
		end
	endtask

	// reset and follow the trace against the model until the core halts
	task automatic run_program(input logic exp_fault);
		logic     wr;
		logic     stop;
		logic     flt;
		logic     got;
		logic     done;
		logic     first;
		reg_idx_t rd;
		word_t    data;
		word_t    pc_seen;
		word_t    gap;
		int       steps;
		load_program();
		apply_reset();
		mpc = `RV_RESET_PC;
		for (int i = 0; i < `RV_NUM_REGS; i++)
			mregs[i] = '0;
		done = 1'b0;
		first = 1'b1;
		while (!done) begin
			wait_event(gap, got);
			wr = 1'b0;
			stop = 1'b0;
			steps = 0;
			if (!got) begin
				done = 1'b1;
			end else if (wb_valid) begin
				// instructions without a write leave no trace and are skipped
				while (!wr && !stop && steps < MAX_STEPS) begin
					pc_seen = mpc;
					model_step(wr, rd, data, stop, flt);
					steps++;
				end
				if (!wr) begin
					errors++;
					$display("%s: core wrote x%0d at pc %h but the model makes no write",
						test_name, wb_rd, wb_pc);
					done = 1'b1;
				end else begin
					check_idx("wb_rd", rd, wb_rd);
					check_word("wb_data", data, wb_data);
					check_word("wb_pc", pc_seen, wb_pc);
					check_flag("psel in execute", 1'b0, psel);
					if (check_spacing && !first)
						check_word("wb spacing", 32'd3, gap);
					first = 1'b0;
				end
			end else begin
				while (!stop && steps < MAX_STEPS) begin
					pc_seen = mpc;
					model_step(wr, rd, data, stop, flt);
					steps++;
					if (wr) begin
						errors++;
						$display("%s: core halted but the model still writes x%0d at pc %h",
							test_name, rd, pc_seen);
					end
				end
				check_flag("model stop", 1'b1, stop);
				check_flag("fault", flt, fault);
				check_flag("fault kind", exp_fault, fault);
				for (int i = 0; i < HALT_WINDOW; i++) begin
					@(negedge clk);
					check_flag("psel after halt", 1'b0, psel);
					check_flag("halted held", 1'b1, halted);
				end
				done = 1'b1;
			end
		end
	endtask

	// signed and unsigned compares, negative immediates, x0 targets
	task automatic build_alu_program();
		prog.push_back(enc_i(100, 0, 0, 1, `RV_OPC_OP_IMM));
		prog.push_back(enc_i(-7, 0, 0, 2, `RV_OPC_OP_IMM));
		prog.push_back(enc_r(0, 2, 1, 0, 3));
		prog.push_back(enc_r(32, 1, 2, 0, 4));
		prog.push_back(enc_r(0, 2, 1, 7, 5));
		prog.push_back(enc_r(0, 2, 1, 6, 6));
		prog.push_back(enc_r(0, 2, 1, 4, 7));
		prog.push_back(enc_r(0, 1, 2, 2, 8));
		prog.push_back(enc_r(0, 1, 2, 3, 9));
		prog.push_back(enc_i(-1, 2, 2, 10, `RV_OPC_OP_IMM));
		prog.push_back(enc_i(-1, 1, 3, 11, `RV_OPC_OP_IMM));
		prog.push_back(enc_i(12'h0f0, 2, 7, 12, `RV_OPC_OP_IMM));
		prog.push_back(enc_i(-256, 1, 6, 13, `RV_OPC_OP_IMM));
		prog.push_back(enc_i(-1, 2, 4, 14, `RV_OPC_OP_IMM));
		prog.push_back(enc_i(5, 1, 0, 0, `RV_OPC_OP_IMM));
		prog.push_back(enc_r(0, 2, 1, 0, 0));
		prog.push_back(EBREAK);
	endtask

	task automatic test_alu_ops();
		test_name = "test_alu_ops";
		use_waits = 1'b0;
		build_alu_program();
		run_program(1'b0);
	endtask

	task automatic test_upper_and_jumps();
		test_name = "test_upper_and_jumps";
		use_waits = 1'b0;
		prog.push_back(enc_u(20'h12345, 1, `RV_OPC_LUI));
		prog.push_back(enc_u(20'h00001, 2, `RV_OPC_AUIPC));
		prog.push_back(enc_j(12, 3));
		prog.push_back(enc_i(1, 0, 0, 4, `RV_OPC_OP_IMM));
		prog.push_back(enc_i(2, 0, 0, 4, `RV_OPC_OP_IMM));
		prog.push_back(enc_i(32'h30, 0, 0, 5, `RV_OPC_OP_IMM));
		// 0x30 + 5 is odd so the target lands on 0x34
		prog.push_back(enc_i(5, 5, 0, 6, `RV_OPC_JALR));
		prog.push_back(enc_i(9, 0, 0, 7, `RV_OPC_OP_IMM));
		prog.push_back(EBREAK);
		for (int i = 0; i < 4; i++)
			prog.push_back(enc_i(3, 0, 0, 4, `RV_OPC_OP_IMM));
		prog.push_back(enc_i(11, 0, 0, 8, `RV_OPC_OP_IMM));
		prog.push_back(enc_j(8, 9));
		prog.push_back(enc_i(4, 0, 0, 4, `RV_OPC_OP_IMM));
		// backward jump from 0x40 to 0x1c
		prog.push_back(enc_j(-36, 10));
		run_program(1'b0);
	endtask

	task automatic test_zero_wait_timing();
		test_name = "test_zero_wait_timing";
		use_waits = 1'b0;
		check_spacing = 1'b1;
		prog.push_back(enc_i(1, 0, 0, 1, `RV_OPC_OP_IMM));
		prog.push_back(enc_i(2, 1, 0, 2, `RV_OPC_OP_IMM));
		prog.push_back(enc_r(0, 2, 1, 0, 3));
		prog.push_back(enc_i(5, 3, 4, 4, `RV_OPC_OP_IMM));
		prog.push_back(enc_r(32, 1, 4, 0, 5));
		prog.push_back(enc_i(8, 5, 6, 6, `RV_OPC_OP_IMM));
		prog.push_back(EBREAK);
		run_program(1'b0);
		check_spacing = 1'b0;
	endtask

	task automatic test_wait_states();
		test_name = "test_wait_states";
		use_waits = 1'b1;
		stall_count = 0;
		build_alu_program();
		run_program(1'b0);
		check_flag("stalls seen", 1'b1, stall_count > 0);
		use_waits = 1'b0;
	endtask

	task automatic test_halt();
		test_name = "test_halt";
		prog.push_back(enc_i(3, 0, 0, 1, `RV_OPC_OP_IMM));
		prog.push_back(enc_r(0, 1, 1, 0, 2));
		prog.push_back(EBREAK);
		run_program(1'b0);
	endtask

	task automatic test_faults();
		test_name = "test_faults illegal";
		prog.push_back(enc_i(1, 0, 0, 3, `RV_OPC_OP_IMM));
		// slli is outside the subset
		prog.push_back(enc_i(1, 3, 1, 4, `RV_OPC_OP_IMM));
		prog.push_back(enc_i(7, 0, 0, 5, `RV_OPC_OP_IMM));
		run_program(1'b1);
		test_name = "test_faults pslverr";
		prog.push_back(enc_i(7, 0, 0, 1, `RV_OPC_OP_IMM));
		// jump from 0x4 to 0x104 past the end of memory
		prog.push_back(enc_j(32'h100, 2));
		run_program(1'b1);
	endtask

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		prdata = '0;
		pready = 1'b0;
		pslverr = 1'b0;
		use_waits = 1'b0;
		check_spacing = 1'b0;
		was_setup = 1'b0;
		errors = 0;
		stall_count = 0;
		test_name = "startup";
		test_alu_ops();
		test_upper_and_jumps();
		test_zero_wait_timing();
		test_wait_states();
		test_halt();
		test_faults();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
